// File: hw/stream_params.svh
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Width of one element on the element side.
`define STREAM_ELEM_WIDTH 16

// Elements carried by one AXI beat.
`define STREAM_NUM_ELEMS 4

// Full AXI data width, byte keep is this divided by eight.
`define STREAM_AXI_WIDTH (`STREAM_ELEM_WIDTH * `STREAM_NUM_ELEMS)

`endif

// File: hw/stream_pkg.sv
`include "stream_params.svh"

package stream_pkg;

    // One element of the stream.
    typedef logic [`STREAM_ELEM_WIDTH-1:0] elem_t;

    // Operation applied to every kept element of a packet.
    typedef enum logic [1:0] {
        op_pass  = 2'd0, // Element unchanged.
        op_add   = 2'd1, // Wrapping add of the operand.
        op_xor   = 2'd2, // Bitwise xor with the operand.
        op_clamp = 2'd3  // Unsigned minimum with the operand.
    } op_e;

    // Decode stage position within a packet.
    typedef enum logic {
        st_header = 1'b0, // Waiting for a header beat.
        st_body   = 1'b1  // Passing data beats through.
    } dec_state_e;

endpackage

// File: hw/ndata_if.sv
`timescale 1ns/1ps

`include "stream_params.svh"

// A word of elements with per-element keep and ready/valid handshake.
interface ndata_if;

    stream_pkg::elem_t [`STREAM_NUM_ELEMS-1:0] data;
    logic [`STREAM_NUM_ELEMS-1:0]              keep; // One bit per element.
    logic                                      last; // Final word of a packet.
    logic                                      valid;
    logic                                      ready;

    modport src (
        output data,
        output keep,
        output last,
        output valid,
        input  ready
    );

    modport dst (
        input  data,
        input  keep,
        input  last,
        input  valid,
        output ready
    );

endinterface

// File: hw/header_decode.sv
`timescale 1ns/1ps

`include "stream_params.svh"

module header_decode (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [`STREAM_AXI_WIDTH-1:0]       axis_tdata,
    input  logic [`STREAM_AXI_WIDTH/8-1:0]     axis_tkeep,
    input  logic                               axis_tlast,
    input  logic                               axis_tvalid,
    output logic                               axis_tready,

    ndata_if.src                               out,

    output stream_pkg::op_e                    op,
    output stream_pkg::elem_t                  operand
);

    localparam int ELEM_WIDTH = `STREAM_ELEM_WIDTH;
    localparam int NUM_ELEMS  = `STREAM_NUM_ELEMS;
    localparam int ELEM_BYTES = ELEM_WIDTH / 8;

    stream_pkg::dec_state_e state;

    logic in_header;
    logic hdr_accept;
    logic body_accept;

    assign in_header = (state == stream_pkg::st_header);

    // Header beats are always taken, body beats wait for downstream.
    assign axis_tready = in_header ? 1'b1 : out.ready;

    assign hdr_accept  = in_header && axis_tvalid;
    assign body_accept = !in_header && axis_tvalid && out.ready;

    // Unpack each data beat into elements.
    for (genvar i = 0; i < NUM_ELEMS; i++) begin : g_unpack
        assign out.data[i] = axis_tdata[i*ELEM_WIDTH +: ELEM_WIDTH];
        // Element keep comes from its lowest byte.
        assign out.keep[i] = axis_tkeep[i*ELEM_BYTES];
    end

    assign out.last  = axis_tlast;
    assign out.valid = !in_header && axis_tvalid; // Header never reaches the ALU.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= stream_pkg::st_header;
            op      <= stream_pkg::op_pass;
            operand <= '0;
        end else begin
            case (state)
                stream_pkg::st_header: begin
                    if (hdr_accept) begin
                        op      <= stream_pkg::op_e'(axis_tdata[1:0]); // Element 0, low bits.
                        operand <= axis_tdata[ELEM_WIDTH +: ELEM_WIDTH]; // Element 1.
                        // A header with last is an empty packet.
                        if (!axis_tlast) begin
                            state <= stream_pkg::st_body;
                        end
                    end
                end
                stream_pkg::st_body: begin
                    if (body_accept && axis_tlast) begin
                        state <= stream_pkg::st_header; // Packet done.
                    end
                end
                default: begin
                    state <= stream_pkg::st_header;
                end
            endcase
        end
    end

endmodule

// File: hw/elem_alu.sv
`timescale 1ns/1ps

`include "stream_params.svh"

module elem_alu (
    input  logic              clk,
    input  logic              rst_n,

    ndata_if.dst              in,

    input  stream_pkg::op_e   op,
    input  stream_pkg::elem_t operand,

    ndata_if.src              out
);

    localparam int NUM_ELEMS = `STREAM_NUM_ELEMS;

    stream_pkg::elem_t [NUM_ELEMS-1:0] result;
    stream_pkg::elem_t [NUM_ELEMS-1:0] data_q;
    logic [NUM_ELEMS-1:0]              keep_q;
    logic                              last_q;
    logic                              valid_q;
    logic                              accept;

    function automatic stream_pkg::elem_t apply_op(
        input stream_pkg::op_e   code,
        input stream_pkg::elem_t a,
        input stream_pkg::elem_t b
    );
        stream_pkg::elem_t sum_v;
        stream_pkg::elem_t xor_v;
        stream_pkg::elem_t min_v;
        sum_v = a + b; // Wraps at element width.
        xor_v = a ^ b;
        min_v = (a < b) ? a : b; // Unsigned compare.
        unique case (code)
            stream_pkg::op_pass:  apply_op = a;
            stream_pkg::op_add:   apply_op = sum_v;
            stream_pkg::op_xor:   apply_op = xor_v;
            stream_pkg::op_clamp: apply_op = min_v;
        endcase
    endfunction

    // Dropped elements ride along untouched.
    for (genvar i = 0; i < NUM_ELEMS; i++) begin : g_elem
        assign result[i] = in.keep[i] ? apply_op(op, in.data[i], operand) : in.data[i];
    end

    // Take a new word when empty or when the held one leaves this cycle.
    assign in.ready = !valid_q || out.ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0; // Drained with nothing behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= result;
            keep_q <= in.keep;
            last_q <= in.last;
        end
    end

    assign out.data  = data_q;
    assign out.keep  = keep_q;
    assign out.last  = last_q;
    assign out.valid = valid_q;

endmodule

// File: hw/elem_serializer.sv
`timescale 1ns/1ps

`include "stream_params.svh"

module elem_serializer (
    input  logic              clk,
    input  logic              rst_n,

    ndata_if.dst              in,

    output stream_pkg::elem_t elem_data,
    output logic              elem_keep,
    output logic              elem_last,
    output logic              elem_valid,
    input  logic              elem_ready
);

    localparam int NUM_ELEMS = `STREAM_NUM_ELEMS;
    localparam int CNT_WIDTH = $clog2(NUM_ELEMS);

    logic [CNT_WIDTH-1:0] counter;
    logic                 final_elem;
    logic                 beat_done;

    assign final_elem = (counter == CNT_WIDTH'(NUM_ELEMS - 1));
    assign beat_done  = in.valid && elem_ready;

    // Word is released only with its final element.
    assign in.ready = elem_ready && final_elem;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counter <= '0;
        end else if (beat_done) begin
            if (final_elem) begin
                counter <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Pick the current element out of the held word.
    assign elem_data  = in.data[counter];
    assign elem_keep  = in.keep[counter];
    assign elem_last  = in.last && final_elem; // Last element of the packet only.
    assign elem_valid = in.valid;

endmodule

// File: hw/stream_top.sv
`timescale 1ns/1ps

`include "stream_params.svh"

module stream_top (
    input  logic                           clk,
    input  logic                           rst_n,

    // AXI input with header beats.
    input  logic [`STREAM_AXI_WIDTH-1:0]   axis_tdata,
    input  logic [`STREAM_AXI_WIDTH/8-1:0] axis_tkeep,
    input  logic                           axis_tlast,
    input  logic                           axis_tvalid,
    output logic                           axis_tready,

    // One element per beat.
    output logic [`STREAM_ELEM_WIDTH-1:0]  elem_data,
    output logic                           elem_keep,
    output logic                           elem_last,
    output logic                           elem_valid,
    input  logic                           elem_ready
);

    ndata_if dec_if ();
    ndata_if alu_if ();

    stream_pkg::op_e   op;
    stream_pkg::elem_t operand;

    header_decode dec_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .axis_tdata  (axis_tdata),
        .axis_tkeep  (axis_tkeep),
        .axis_tlast  (axis_tlast),
        .axis_tvalid (axis_tvalid),
        .axis_tready (axis_tready),
        .out         (dec_if.src),
        .op          (op),
        .operand     (operand)
    );

    elem_alu alu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in      (dec_if.dst),
        .op      (op),
        .operand (operand),
        .out     (alu_if.src)
    );

    elem_serializer ser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in         (alu_if.dst),
        .elem_data  (elem_data),
        .elem_keep  (elem_keep),
        .elem_last  (elem_last),
        .elem_valid (elem_valid),
        .elem_ready (elem_ready)
    );

endmodule

// File: tests/stream_checker.sv
`timescale 1ns/1ps

`include "stream_params.svh"

module stream_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic [`STREAM_ELEM_WIDTH-1:0] elem_data,
    input logic                          elem_keep,
    input logic                          elem_last,
    input logic                          elem_valid,
    input logic                          elem_ready
);

    int failures = 0; // Read by the testbench at the end of the run.

    // Output side comes up idle.
    reset_idle: assert property (@(posedge clk) !rst_n |=> !elem_valid)
        else begin
            failures++;
            $error("elem_valid high right after reset");
        end

    // A stalled element beat must hold its contents.
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (elem_valid && !elem_ready) |=>
            (elem_valid && $stable(elem_data) && $stable(elem_keep) && $stable(elem_last)))
        else begin
            failures++;
            $error("element beat changed while stalled");
        end

    last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        elem_last |-> elem_valid)
        else begin
            failures++;
            $error("elem_last high without elem_valid");
        end

endmodule

bind stream_top stream_checker checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .elem_data  (elem_data),
    .elem_keep  (elem_keep),
    .elem_last  (elem_last),
    .elem_valid (elem_valid),
    .elem_ready (elem_ready)
);

// File: tests/stream_tb.sv
`timescale 1ns/1ps

`include "stream_params.svh"

module stream_tb;

    localparam int AXI_WIDTH  = `STREAM_AXI_WIDTH;
    localparam int KEEP_WIDTH = `STREAM_AXI_WIDTH / 8;
    localparam int ELEM_WIDTH = `STREAM_ELEM_WIDTH;
    localparam int NUM_ELEMS  = `STREAM_NUM_ELEMS;
    localparam int ELEM_BYTES = `STREAM_ELEM_WIDTH / 8;
    localparam int NUM_ROWS   = 10;
    localparam int WAIT_LIMIT = 200;  // Cycles per handshake.
    localparam int DRAIN_LIMIT = 2000;

    // One packet: opcode, operand, data words and kept elements in the tail.
    typedef struct {
        stream_pkg::op_e   op;
        stream_pkg::elem_t operand;
        int                words;
        int                tail_kept;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic [AXI_WIDTH-1:0]  axis_tdata;
    logic [KEEP_WIDTH-1:0] axis_tkeep;
    logic                  axis_tlast;
    logic                  axis_tvalid;
    logic                  axis_tready;
    logic [ELEM_WIDTH-1:0] elem_data;
    logic                  elem_keep;
    logic                  elem_last;
    logic                  elem_valid;
    logic                  elem_ready;

    row_t                  table_rows [NUM_ROWS];
    integer                seed;
    logic                  stall_mode;
    int                    out_idx;

    logic [AXI_WIDTH-1:0]  stim_data [$];
    logic [KEEP_WIDTH-1:0] stim_keep [$];
    logic                  stim_last [$];
    stream_pkg::elem_t     exp_data [$];
    logic                  exp_keep [$];
    logic                  exp_last [$];

    stream_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_elem(input string name, input stream_pkg::elem_t got,
                              input stream_pkg::elem_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got 0x%04h, expected 0x%04h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Opcode rules applied to one kept element.
    function automatic stream_pkg::elem_t model_op(input stream_pkg::op_e code,
                                                   input stream_pkg::elem_t operand,
                                                   input stream_pkg::elem_t value);
        case (code)
            stream_pkg::op_add:   return value + operand; // Wraps at 16 bits.
            stream_pkg::op_xor:   return value ^ operand;
            stream_pkg::op_clamp: return (value < operand) ? value : operand;
            default:              return value;
        endcase
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic fill_table();
        table_rows[0] = '{stream_pkg::op_pass,  16'h1234, 2, 4};
        table_rows[1] = '{stream_pkg::op_add,   16'hffff, 2, 3}; // Add wraps.
        table_rows[2] = '{stream_pkg::op_add,   16'h0001, 1, 4};
        table_rows[3] = '{stream_pkg::op_xor,   16'ha5a5, 3, 1};
        table_rows[4] = '{stream_pkg::op_clamp, 16'h8000, 2, 2};
        table_rows[5] = '{stream_pkg::op_xor,   16'h00ff, 0, 0}; // Empty packet.
        table_rows[6] = '{stream_pkg::op_clamp, 16'h0000, 1, 4};
        table_rows[7] = '{stream_pkg::op_add,   16'h7fff, 3, 4};
        table_rows[8] = '{stream_pkg::op_clamp, 16'h1111, 0, 0};
        table_rows[9] = '{stream_pkg::op_pass,  16'hbeef, 1, 1};
    endtask

    // Builds all beats and the expected element stream once.
    task automatic build_stimulus();
        logic [31:0]           r;
        logic [31:0]           r2;
        logic [AXI_WIDTH-1:0]  word;
        logic [KEEP_WIDTH-1:0] keep;
        stream_pkg::elem_t     val;
        logic                  tail;
        logic                  kept;
        row_t                  row;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = table_rows[i];
            r = $random(seed);
            r2 = $random(seed);
            // Header with junk above the opcode bits.
            stim_data.push_back({r, row.operand, r2[15:2], row.op});
            stim_keep.push_back(r2[23:16]);
            stim_last.push_back(row.words == 0);
            for (int w = 0; w < row.words; w++) begin
                tail = (w == row.words - 1);
                for (int e = 0; e < NUM_ELEMS; e++) begin
                    r = $random(seed);
                    val = r[15:0];
                    if (w == 0) begin
                        // Boundary values around the operand.
                        case (e)
                            0: val = row.operand;
                            1: val = row.operand + 16'd1;
                            2: val = row.operand - 16'd1;
                            default: val = 16'hffff;
                        endcase
                    end
                    kept = !tail || (e < row.tail_kept);
                    word[e*ELEM_WIDTH +: ELEM_WIDTH] = val;
                    keep[e*ELEM_BYTES +: ELEM_BYTES] = kept ? '1 : '0;
                    exp_data.push_back(kept ? model_op(row.op, row.operand, val) : val);
                    exp_keep.push_back(kept);
                    exp_last.push_back(tail && (e == NUM_ELEMS - 1));
                end
                stim_data.push_back(word);
                stim_keep.push_back(keep);
                stim_last.push_back(tail);
            end
        end
    endtask

    task automatic send_beat(input logic [AXI_WIDTH-1:0] data,
                             input logic [KEEP_WIDTH-1:0] keep, input logic last,
                             input logic header);
        int waited;
        waited = 0;
        axis_tdata  <= data;
        axis_tkeep  <= keep;
        axis_tlast  <= last;
        axis_tvalid <= 1'b1;
        @(negedge clk);
        if (header) begin
            // Header beats never wait for downstream.
            check_bit("axis_tready", axis_tready, 1'b1);
        end
        while (!axis_tready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout waiting for axis_tready");
            end
            @(negedge clk);
        end
        @(posedge clk); // Beat accepted here.
    endtask

    task automatic collect_outputs();
        forever begin
            @(posedge clk);
            elem_ready <= stall_mode ? random_bit() : 1'b1;
            @(negedge clk);
            if (dut_i.checker_i.failures != 0) begin
                report_failure("output checker flagged an assertion failure");
            end
            if (elem_valid && elem_ready) begin
                if (out_idx >= exp_data.size()) begin
                    report_failure("output beat arrived after the expected stream ended");
                end
                check_elem($sformatf("elem_data[%0d]", out_idx), elem_data, exp_data[out_idx]);
                check_bit($sformatf("elem_keep[%0d]", out_idx), elem_keep, exp_keep[out_idx]);
                check_bit($sformatf("elem_last[%0d]", out_idx), elem_last, exp_last[out_idx]);
                out_idx++;
            end
        end
    endtask

    task automatic run_phase(input logic stalls);
        int   waited;
        logic at_header;
        waited = 0;
        at_header = 1'b1;
        stall_mode = stalls;
        out_idx = 0;
        @(posedge clk);
        foreach (stim_data[i]) begin
            send_beat(stim_data[i], stim_keep[i], stim_last[i], at_header);
            at_header = stim_last[i]; // A beat with last is followed by a header.
        end
        axis_tvalid <= 1'b0;
        while (out_idx < exp_data.size()) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                report_failure("timeout waiting for the output stream to drain");
            end
            @(negedge clk);
        end
        repeat (8) @(negedge clk); // Room for any stray extra beat.
    endtask

    initial begin
        seed        = 32'hda84;
        rst_n       = 1'b0;
        axis_tdata  = '0;
        axis_tkeep  = '0;
        axis_tlast  = 1'b0;
        axis_tvalid = 1'b0;
        elem_ready  = 1'b0;
        stall_mode  = 1'b0;
        out_idx     = 0;
        fill_table();
        build_stimulus();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fork
            collect_outputs();
        join_none
        run_phase(1'b0); // Free-flowing output.
        run_phase(1'b1); // Random elem_ready.
        if (dut_i.checker_i.failures == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("stream_checker reported %0d assertion failures",
                     dut_i.checker_i.failures);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failures in the output checker");
        end
    end

endmodule

// File: build.f
+incdir+hw
hw/stream_pkg.sv
hw/ndata_if.sv
hw/header_decode.sv
hw/elem_alu.sv
hw/elem_serializer.sv
hw/stream_top.sv
tests/stream_checker.sv
tests/stream_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the stream testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module stream_tb -f build.f -o stream_sim

# The simulator exits non-zero on a fatal stop, the log decides the result.
./obj_dir/stream_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
